//--- rtl/ntt_config.svh
`ifndef NTT_CONFIG_SVH
`define NTT_CONFIG_SVH

// coefficients per polynomial, one bank holds one polynomial
`define RING_SIZE 64

// index width, RING_SIZE is a power of two
`define ADDR_WIDTH 6

// coefficient and modulus width
`define COEF_WIDTH 32

// operand entry to result in mod_mul
`define MUL_LATENCY 3

`endif

//--- rtl/ntt_pkg.sv
`default_nettype none

`include "ntt_config.svh"

package ntt_pkg;

    typedef logic [`COEF_WIDTH-1:0] coef_t;   // coefficient or modulus
    typedef logic [`ADDR_WIDTH-1:0] addr_t;   // index inside a bank

    // command codes, same numbering as the full accelerator
    typedef enum logic [3:0] {
        OP_IDLE      = 4'd0,
        OP_READ_PSET = 4'd1,
        OP_READ_DATA = 4'd3,
        OP_SEND_DATA = 4'd5,
        OP_COEFMUL   = 4'd11
    } op_code_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_PSET,
        ST_READ_DATA,
        ST_COEFMUL,
        ST_SEND_DATA
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/poly_bram.sv
`default_nettype none

`include "ntt_config.svh"

module poly_bram
    import ntt_pkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  addr_t waddr,
    input  coef_t wdata,
    input  addr_t raddr,
    output coef_t rdata
);

    coef_t mem [`RING_SIZE];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- rtl/mod_mul.sv
`default_nettype none

`include "ntt_config.svh"

module mod_mul
    import ntt_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  in_valid,
    input  addr_t in_addr,
    input  coef_t a,
    input  coef_t b,
    input  coef_t q,
    output logic  out_valid,
    output addr_t out_addr,
    output coef_t out_data
);

    logic [`MUL_LATENCY-1:0] vld_sr;
    addr_t                   addr_sr [`MUL_LATENCY];

    coef_t                    a_r;
    coef_t                    b_r;
    logic [2*`COEF_WIDTH-1:0] prod_r;
    logic [2*`COEF_WIDTH-1:0] rem;

    // valid and index ride alongside the data stages
    always_ff @(posedge clk) begin
        if (reset)
            vld_sr <= '0;
        else
            vld_sr <= {vld_sr[`MUL_LATENCY-2:0], in_valid};
    end

    always_ff @(posedge clk) begin
        addr_sr[0] <= in_addr;
        for (int i = 1; i < `MUL_LATENCY; i++) begin
            addr_sr[i] <= addr_sr[i-1];
        end
    end

    assign out_valid = vld_sr[`MUL_LATENCY-1];
    assign out_addr  = addr_sr[`MUL_LATENCY-1];

    // stage one
    always_ff @(posedge clk) begin
        a_r <= a;
        b_r <= b;
    end

    // stage two, full width product
    always_ff @(posedge clk) begin
        prod_r <= (2*`COEF_WIDTH)'(a_r) * (2*`COEF_WIDTH)'(b_r);
    end

    // q is held steady for the whole operation
    assign rem = prod_r % (2*`COEF_WIDTH)'(q);

    always_ff @(posedge clk) begin
        out_data <= rem[`COEF_WIDTH-1:0];   // remainder is below q
    end

endmodule

`default_nettype wire

//--- rtl/ntt_cmd_ctrl.sv
`default_nettype none

`include "ntt_config.svh"

module ntt_cmd_ctrl
    import ntt_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  op_code_t op_code,
    input  logic     din_valid,
    input  coef_t    din,
    input  logic     mul_out_valid,
    input  addr_t    mul_out_addr,
    input  coef_t    mul_out_data,
    input  coef_t    bank_a_rdata,
    output coef_t    q,
    output logic     a_we,
    output addr_t    a_waddr,
    output coef_t    a_wdata,
    output logic     b_we,
    output addr_t    b_waddr,
    output coef_t    b_wdata,
    output addr_t    raddr,
    output logic     mul_in_valid,
    output addr_t    mul_in_addr,
    output coef_t    dout,
    output logic     dout_valid,
    output logic     done
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    logic [`ADDR_WIDTH+1:0] word_cnt;    // saturates once both banks are full
    logic [`ADDR_WIDTH:0]   issue_cnt;   // top bit set when all indices issued
    addr_t                  ret_cnt;
    logic [1:0]             load_half;
    logic                   load_en;
    logic                   issue_en;
    logic                   sel_mul;
    logic                   send_rd_valid;
    logic                   mul_last;
    logic                   send_last;

    assign load_en   = (state == ST_READ_DATA) && din_valid;
    assign load_half = word_cnt[`ADDR_WIDTH+1:`ADDR_WIDTH];   // 00 bank A, 01 bank B, 1x drop
    assign sel_mul   = (state == ST_COEFMUL);

    assign issue_en = ((state == ST_COEFMUL) || (state == ST_SEND_DATA))
                      && !issue_cnt[`ADDR_WIDTH];

    assign mul_last = sel_mul && mul_out_valid && (ret_cnt == addr_t'(`RING_SIZE - 1));

    // last word on dout, the read pipe has drained
    assign send_last = (state == ST_SEND_DATA) && issue_cnt[`ADDR_WIDTH]
                       && dout_valid && !send_rd_valid;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                case (op_code)
                    OP_IDLE:      next_state = ST_IDLE;
                    OP_READ_PSET: next_state = ST_READ_PSET;
                    OP_READ_DATA: next_state = ST_READ_DATA;
                    OP_COEFMUL:   next_state = ST_COEFMUL;
                    OP_SEND_DATA: next_state = ST_SEND_DATA;
                    default:      next_state = ST_IDLE;   // unknown codes ignored
                endcase
            end
            ST_READ_PSET: begin
                if (din_valid)
                    next_state = ST_IDLE;
            end
            ST_READ_DATA: begin
                if (!din_valid)
                    next_state = ST_IDLE;
            end
            ST_COEFMUL: begin
                if (mul_last)
                    next_state = ST_IDLE;
            end
            ST_SEND_DATA: begin
                if (send_last)
                    next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    // modulus, first valid word after the op code
    always_ff @(posedge clk) begin
        if (reset)
            q <= '0;
        else if ((state == ST_READ_PSET) && din_valid)
            q <= din;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_cnt <= '0;
        end else if (load_en) begin
            if (!word_cnt[`ADDR_WIDTH+1])
                word_cnt <= word_cnt + 1'b1;
        end else begin
            word_cnt <= '0;
        end
    end

    // bank A takes the multiplier results during COEFMUL, loaded words otherwise
    always_comb begin
        if (sel_mul) begin
            a_we    = mul_out_valid;
            a_waddr = mul_out_addr;
            a_wdata = mul_out_data;
        end else begin
            a_we    = load_en && (load_half == 2'b00);
            a_waddr = word_cnt[`ADDR_WIDTH-1:0];
            a_wdata = din;
        end
    end

    assign b_we    = load_en && (load_half == 2'b01);
    assign b_waddr = word_cnt[`ADDR_WIDTH-1:0];
    assign b_wdata = din;

    always_ff @(posedge clk) begin
        if (reset)
            issue_cnt <= '0;
        else if (state == ST_IDLE)
            issue_cnt <= '0;
        else if (issue_en)
            issue_cnt <= issue_cnt + 1'b1;
    end

    assign raddr = issue_cnt[`ADDR_WIDTH-1:0];   // shared by both banks

    always_ff @(posedge clk) begin
        if (reset)
            ret_cnt <= '0;
        else if (!sel_mul)
            ret_cnt <= '0;
        else if (mul_out_valid)
            ret_cnt <= ret_cnt + 1'b1;
    end

    // one cycle behind raddr to match the bank read
    always_ff @(posedge clk) begin
        if (reset) begin
            mul_in_valid  <= 1'b0;
            send_rd_valid <= 1'b0;
            dout_valid    <= 1'b0;
            done          <= 1'b0;
        end else begin
            mul_in_valid  <= issue_en && sel_mul;
            send_rd_valid <= issue_en && (state == ST_SEND_DATA);
            dout_valid    <= send_rd_valid;
            done          <= mul_last || send_last;
        end
    end

    always_ff @(posedge clk) begin
        mul_in_addr <= raddr;
    end

    always_ff @(posedge clk) begin
        if (reset)
            dout <= '0;
        else
            dout <= send_rd_valid ? bank_a_rdata : '0;   // zero between streams
    end

endmodule

`default_nettype wire

//--- rtl/ntt_core.sv
`default_nettype none

module ntt_core
    import ntt_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  op_code_t op_code,
    input  logic     din_valid,
    input  coef_t    din,
    output coef_t    dout,
    output logic     dout_valid,
    output logic     done
);

    coef_t q;

    logic  a_we;
    addr_t a_waddr;
    coef_t a_wdata;
    coef_t a_rdata;

    logic  b_we;
    addr_t b_waddr;
    coef_t b_wdata;
    coef_t b_rdata;

    addr_t raddr;   // same index into both banks

    logic  mul_in_valid;
    addr_t mul_in_addr;
    logic  mul_out_valid;
    addr_t mul_out_addr;
    coef_t mul_out_data;

    ntt_cmd_ctrl cmd_ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .op_code       (op_code),
        .din_valid     (din_valid),
        .din           (din),
        .mul_out_valid (mul_out_valid),
        .mul_out_addr  (mul_out_addr),
        .mul_out_data  (mul_out_data),
        .bank_a_rdata  (a_rdata),
        .q             (q),
        .a_we          (a_we),
        .a_waddr       (a_waddr),
        .a_wdata       (a_wdata),
        .b_we          (b_we),
        .b_waddr       (b_waddr),
        .b_wdata       (b_wdata),
        .raddr         (raddr),
        .mul_in_valid  (mul_in_valid),
        .mul_in_addr   (mul_in_addr),
        .dout          (dout),
        .dout_valid    (dout_valid),
        .done          (done)
    );

    // bank A also receives the products
    poly_bram bank_a_i (
        .clk   (clk),
        .we    (a_we),
        .waddr (a_waddr),
        .wdata (a_wdata),
        .raddr (raddr),
        .rdata (a_rdata)
    );

    poly_bram bank_b_i (
        .clk   (clk),
        .we    (b_we),
        .waddr (b_waddr),
        .wdata (b_wdata),
        .raddr (raddr),
        .rdata (b_rdata)
    );

    mod_mul mod_mul_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_in_valid),
        .in_addr   (mul_in_addr),
        .a         (a_rdata),
        .b         (b_rdata),
        .q         (q),
        .out_valid (mul_out_valid),
        .out_addr  (mul_out_addr),
        .out_data  (mul_out_data)
    );

endmodule

`default_nettype wire

//--- tests/ntt_core_tb.sv
`default_nettype none

`include "ntt_config.svh"

module ntt_core_tb
    import ntt_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int DONE_LIMIT      = `RING_SIZE + `MUL_LATENCY + 20;
    localparam int WATCHDOG_CYCLES = 12 * (2 * `RING_SIZE + `MUL_LATENCY + 20) + RESET_CYCLES;

    logic     clk;
    logic     reset;
    op_code_t op_code;
    logic     din_valid;
    coef_t    din;
    coef_t    dout;
    logic     dout_valid;
    logic     done;

    logic [31:0] lfsr_state = 32'h9f23_1fd7;

    coef_t model_a [`RING_SIZE];   // mirror of bank A
    coef_t model_b [`RING_SIZE];
    coef_t model_q;
    coef_t stream_words [$];

    int errors = 0;
    int err_at_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ntt_core ntt_core_i (
        .clk        (clk),
        .reset      (reset),
        .op_code    (op_code),
        .din_valid  (din_valid),
        .din        (din),
        .dout       (dout),
        .dout_valid (dout_valid),
        .done       (done)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int nbits, output coef_t val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[`COEF_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;   // drive and sample just after the edge
    endtask

    task automatic check_coef(input string name, input coef_t expected, input coef_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // op code is seen by the idle controller on the edge after this drive
    task automatic start_op(input op_code_t op);
        step();
        op_code = op;
        step();
        op_code = OP_IDLE;
    endtask

    task automatic load_q(input coef_t value);
        start_op(OP_READ_PSET);
        din_valid = 1'b1;
        din = value;
        step();
        din_valid = 1'b0;
        din = '0;
        model_q = value;
    endtask

    task automatic new_q(output coef_t value);
        rand_bits(`COEF_WIDTH - 1, value);
        value[0] = 1'b1;   // odd, below 2^31
    endtask

    task automatic load_polys(input int nwords);
        coef_t w;
        start_op(OP_READ_DATA);
        for (int k = 0; k < nwords; k++) begin
            rand_bits(`COEF_WIDTH, w);
            din_valid = 1'b1;
            din = w;
            if (k < `RING_SIZE)
                model_a[k] = w;
            else if (k < 2 * `RING_SIZE)
                model_b[k - `RING_SIZE] = w;
            step();
        end
        din_valid = 1'b0;
        din = '0;
        step();
    endtask

    task automatic wait_done(input string name, input int limit, output int done_idx);
        int   n;
        int   stray;
        logic seen;
        n = 0;
        stray = 0;
        seen = 1'b0;
        done_idx = -1;
        while (n < limit && !seen) begin
            step();
            n++;
            if (dout_valid === 1'b1)
                stray++;
            if (done === 1'b1) begin
                seen = 1'b1;
                done_idx = n;
            end
        end
        if (!seen) begin
            $display("%s: done never pulsed within %0d cycles", name, limit);
            errors++;
        end else begin
            step();
            check_bit($sformatf("%s done width", name), 1'b0, done);
        end
        check_count($sformatf("%s dout_valid cycles", name), 0, stray);
    endtask

    task automatic read_stream(input string name, input int limit,
                               output int first_idx, output int done_idx);
        int n;
        stream_words.delete();
        first_idx = -1;
        done_idx = -1;
        n = 0;
        while (n < limit && done_idx < 0) begin
            step();
            n++;
            if (dout_valid === 1'b1) begin
                if (first_idx < 0)
                    first_idx = n;
                stream_words.push_back(dout);
            end
            if (done === 1'b1) begin
                done_idx = n;
                check_bit($sformatf("%s dout_valid with done", name), 1'b0, dout_valid);
            end
        end
        if (done_idx < 0) begin
            $display("%s: send never finished within %0d cycles", name, limit);
            errors++;
        end else begin
            step();
            check_bit($sformatf("%s done width", name), 1'b0, done);
            check_bit($sformatf("%s dout_valid after done", name), 1'b0, dout_valid);
        end
    endtask

    task automatic send_and_compare(input string name);
        int first_idx;
        int done_idx;
        start_op(OP_SEND_DATA);
        read_stream(name, DONE_LIMIT, first_idx, done_idx);
        check_count($sformatf("%s word count", name), `RING_SIZE, stream_words.size());
        check_count($sformatf("%s first word cycle", name), 2, first_idx);
        check_count($sformatf("%s done cycle", name), 2 + `RING_SIZE, done_idx);
        for (int i = 0; i < stream_words.size() && i < `RING_SIZE; i++) begin
            check_coef($sformatf("%s word %0d", name, i), model_a[i], stream_words[i]);
        end
    endtask

    task automatic run_coefmul(input string name);
        logic [2*`COEF_WIDTH-1:0] prod;
        int                       done_idx;
        start_op(OP_COEFMUL);
        for (int i = 0; i < `RING_SIZE; i++) begin
            prod = {{`COEF_WIDTH{1'b0}}, model_a[i]} * {{`COEF_WIDTH{1'b0}}, model_b[i]};
            model_a[i] = coef_t'(prod % {{`COEF_WIDTH{1'b0}}, model_q});
        end
        wait_done(name, DONE_LIMIT, done_idx);
        // done follows the last write into bank A by one cycle
        if (done_idx >= 0)
            check_count($sformatf("%s done cycle", name),
                        `RING_SIZE + `MUL_LATENCY + 1, done_idx);
    endtask

    task automatic begin_test();
        err_at_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == err_at_start) begin
            $display("test %s passed", name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name, errors - err_at_start);
            tests_failed++;
        end
    endtask

    task automatic reset_outputs();
        begin_test();
        for (int i = 0; i < 4; i++) begin
            check_bit("reset_outputs dout_valid", 1'b0, dout_valid);
            check_bit("reset_outputs done", 1'b0, done);
            check_coef("reset_outputs dout", '0, dout);
            step();
        end
        end_test("reset_outputs");
    endtask

    task automatic load_and_send();
        coef_t qv;
        begin_test();
        new_q(qv);
        load_q(qv);
        load_polys(2 * `RING_SIZE + 2);   // two extra words get dropped
        send_and_compare("load_and_send");
        end_test("load_and_send");
    endtask

    task automatic coefmul_result();
        begin_test();
        run_coefmul("coefmul_result mul");
        send_and_compare("coefmul_result send");
        end_test("coefmul_result");
    endtask

    task automatic modulus_change();
        coef_t qv;
        begin_test();
        new_q(qv);
        load_q(qv);
        run_coefmul("modulus_change mul");
        send_and_compare("modulus_change send");
        end_test("modulus_change");
    endtask

    task automatic short_load();
        begin_test();
        load_polys(`RING_SIZE + `RING_SIZE / 4 + 5);   // B only partly rewritten
        run_coefmul("short_load mul");
        send_and_compare("short_load send");
        end_test("short_load");
    endtask

    task automatic unknown_op();
        logic [3:0] bad [2];
        int         hits;
        begin_test();
        bad[0] = 4'd6;
        bad[1] = 4'd15;
        hits = 0;
        for (int c = 0; c < 2; c++) begin
            start_op(op_code_t'(bad[c]));
            for (int i = 0; i < 20; i++) begin
                step();
                if (done !== 1'b0 || dout_valid !== 1'b0)
                    hits++;
            end
        end
        check_count("unknown_op active output cycles", 0, hits);
        send_and_compare("unknown_op send");
        end_test("unknown_op");
    endtask

    initial begin
        reset = 1'b1;
        op_code = OP_IDLE;
        din_valid = 1'b0;
        din = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_outputs();
        load_and_send();
        coefmul_result();
        modulus_change();
        short_load();
        unknown_op();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- ntt_core.f
+incdir+rtl
rtl/ntt_pkg.sv
rtl/poly_bram.sv
rtl/mod_mul.sv
rtl/ntt_cmd_ctrl.sv
rtl/ntt_core.sv
tests/ntt_core_tb.sv

//--- Bender.yml
package:
  name: ntt_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ntt_pkg.sv
      - rtl/poly_bram.sv
      - rtl/mod_mul.sv
      - rtl/ntt_cmd_ctrl.sv
      - rtl/ntt_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/ntt_core_tb.sv
